// File: include/rv32i_config.svh
// reset PC, register count, widths and opcode values for the rv32i stall core

`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

//////////////////////////////////////////////////
// architecture
//////////////////////////////////////////////////

`define RESET_PC        32'h0000_0000
`define NUM_REGS        32
`define XLEN            32
`define REG_IDX_W       5

//////////////////////////////////////////////////
// opcodes
//////////////////////////////////////////////////

`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011

`endif

// File: logic/rv32i_types.sv
// rv32i_types package with word and register index types, stall and operation enums

`include "rv32i_config.svh"

package rv32i_types;

    //////////////////////////////////////////////////
    // vectors
    //////////////////////////////////////////////////

    typedef logic [`XLEN-1:0]      word_t;      // data or address.
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;   // x0..x31.

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    // which memory responses the current step still waits for
    typedef enum logic [1:0] {
        idle,
        wait_imem,
        wait_dmem,
        imem_dmem
    } stall_state;

    typedef enum logic [2:0] {
        op_nop,
        op_addi,
        op_add,
        op_lw,
        op_sw
    } op_kind;

endpackage

// File: logic/ex_mem_if.sv
// ex_mem_if interface carrying one executed instruction from execute to memory/writeback

interface ex_mem_if;

    rv32i_types::op_kind   kind;
    rv32i_types::reg_idx_t rd;
    rv32i_types::word_t    result;      // alu value or memory address.
    rv32i_types::word_t    store_data;

    modport src (
        output kind,
        output rd,
        output result,
        output store_data
    );

    modport dst (
        input  kind,
        input  rd,
        input  result,
        input  store_data
    );

endinterface

// File: logic/stall.sv
// stall FSM tracking outstanding memory responses and producing the move strobe

module stall (
    input   logic   clk,
    input   logic   rst,

    input   logic   imem_next,
    input   logic   dmem_next,
    input   logic   imem_resp,
    input   logic   dmem_resp,

    output  logic   move
);

    rv32i_types::stall_state curr_state, next_state, launch_state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            curr_state <= rv32i_types::idle;
        end else begin
            curr_state <= next_state;
        end
    end

    // wait state for the step that starts after a move.
    always_comb begin
        if (dmem_next && !imem_next) begin
            launch_state = rv32i_types::wait_dmem;
        end else if (!dmem_next && imem_next) begin
            launch_state = rv32i_types::wait_imem;
        end else begin
            launch_state = rv32i_types::imem_dmem;
        end
    end

    always_comb begin
        move       = 1'b0;
        next_state = curr_state;
        unique case (curr_state)
            rv32i_types::idle: begin
                move = 1'b1;                            // kick off the first fetch.
            end
            rv32i_types::wait_imem: begin
                move = imem_resp;
            end
            rv32i_types::wait_dmem: begin
                move = dmem_resp;
            end
            rv32i_types::imem_dmem: begin
                move = imem_resp && dmem_resp;
                if (imem_resp && !dmem_resp) begin
                    next_state = rv32i_types::wait_dmem;
                end else if (dmem_resp && !imem_resp) begin
                    next_state = rv32i_types::wait_imem;
                end
            end
            default: begin
                move = 1'b0;
            end
        endcase
        if (move) begin
            next_state = launch_state;
        end
    end

    //////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////

    // a data step ends only with its response
    a_dmem_move: assert property (@(posedge clk) disable iff (!rst)
        (curr_state inside {rv32i_types::wait_dmem, rv32i_types::imem_dmem} && !dmem_resp) |->
            !move ##1 (curr_state inside {rv32i_types::wait_dmem, rv32i_types::imem_dmem}));

    // memories only answer requests, and idle has none outstanding
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        (curr_state == rv32i_types::idle) |-> !(imem_resp || dmem_resp));

endmodule

// File: logic/fetch.sv
// fetch stage with program counter, instruction request strobe and instruction capture

`include "rv32i_config.svh"

module fetch (
    input   logic                   clk,
    input   logic                   rst,
    input   logic                   move,

    output  logic                   imem_req,
    output  rv32i_types::word_t     imem_addr,
    input   logic                   imem_resp,
    input   rv32i_types::word_t     imem_rdata,

    output  rv32i_types::word_t     instr
);

    localparam rv32i_types::word_t NOP_INSTR = {25'b0, `OPC_OP_IMM};   // addi x0, x0, 0.

    rv32i_types::word_t pc;
    rv32i_types::word_t resp_buf;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc       <= `RESET_PC;
            imem_req <= 1'b0;
            resp_buf <= NOP_INSTR;
            instr    <= NOP_INSTR;
        end else begin
            imem_req <= move;                           // one strobe per step.
            if (imem_resp) begin
                resp_buf <= imem_rdata;
            end
            if (move) begin
                pc    <= pc + 32'd4;
                instr <= imem_resp ? imem_rdata : resp_buf;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            imem_addr <= pc;
        end
    end

    a_single_req: assert property (@(posedge clk) disable iff (!rst)
        imem_req |=> !imem_req);

endmodule

// File: logic/decode_execute.sv
// decode/execute stage with decoder, register file, writeback forwarding and adder

`include "rv32i_config.svh"

module decode_execute (
    input   logic                   clk,
    input   logic                   rst,
    input   logic                   move,

    input   rv32i_types::word_t     instr,
    output  logic                   dmem_next,

    input   logic                   wb_valid,
    input   rv32i_types::reg_idx_t  wb_rd,
    input   rv32i_types::word_t     wb_data,

    ex_mem_if.src                   ex_out
);

    rv32i_types::word_t     regs [`NUM_REGS];

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv32i_types::reg_idx_t  rs1, rs2, rd;
    rv32i_types::op_kind    kind;
    rv32i_types::word_t     imm_i, imm_s;
    rv32i_types::word_t     op_a, op_b, add_b, sum;
    logic                   wb_write;
    logic                   writes_rd;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        kind = rv32i_types::op_nop;                     // anything else runs as a nop.
        unique case (opcode)
            `OPC_OP_IMM: if (funct3 == 3'b000) kind = rv32i_types::op_addi;
            `OPC_OP:     if (funct3 == 3'b000 && funct7 == 7'b0) kind = rv32i_types::op_add;
            `OPC_LOAD:   if (funct3 == 3'b010) kind = rv32i_types::op_lw;
            `OPC_STORE:  if (funct3 == 3'b010) kind = rv32i_types::op_sw;
            default:     kind = rv32i_types::op_nop;
        endcase
    end

    assign writes_rd = (kind == rv32i_types::op_addi) || (kind == rv32i_types::op_add) ||
                       (kind == rv32i_types::op_lw);
    assign dmem_next = (kind == rv32i_types::op_lw) || (kind == rv32i_types::op_sw);

    //////////////////////////////////////////////////
    // operands and adder
    //////////////////////////////////////////////////

    assign wb_write = wb_valid && (wb_rd != '0);

    // the instruction in writeback retires in this same move.
    assign op_a = (wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
    assign op_b = (wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

    always_comb begin
        unique case (kind)
            rv32i_types::op_add: add_b = op_b;
            rv32i_types::op_sw:  add_b = imm_s;
            default:             add_b = imm_i;
        endcase
    end

    assign sum = op_a + add_b;

    //////////////////////////////////////////////////
    // register file and stage register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (move && wb_write) begin
            regs[wb_rd] <= wb_data;                     // x0 never written.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_out.kind <= rv32i_types::op_nop;
        end else if (move) begin
            ex_out.kind <= kind;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            ex_out.rd         <= writes_rd ? rd : '0;
            ex_out.result     <= (kind == rv32i_types::op_nop) ? '0 : sum;
            ex_out.store_data <= op_b;
        end
    end

endmodule

// File: logic/mem_writeback.sv
// memory/writeback stage with data request strobe, load capture and retire report

module mem_writeback (
    input   logic                   clk,
    input   logic                   rst,
    input   logic                   move,

    ex_mem_if.dst                   ex_in,

    output  logic                   dmem_req,
    output  logic                   dmem_we,
    output  rv32i_types::word_t     dmem_addr,
    output  rv32i_types::word_t     dmem_wdata,
    input   logic                   dmem_resp,
    input   rv32i_types::word_t     dmem_rdata,

    output  logic                   wb_valid,
    output  rv32i_types::reg_idx_t  wb_rd,
    output  rv32i_types::word_t     wb_data,

    output  logic                   retire_valid,
    output  rv32i_types::reg_idx_t  retire_rd,
    output  rv32i_types::word_t     retire_data
);

    logic                   step_start;     // first cycle of a step.
    logic [2:0]             fill;           // pipeline warm-up after reset.
    logic                   writes;
    rv32i_types::word_t     load_q;
    rv32i_types::word_t     wr_value;

    always_ff @(posedge clk) begin
        if (!rst) begin
            step_start <= 1'b0;
            fill       <= '0;
        end else begin
            step_start <= move;
            if (move) begin
                fill <= {fill[1:0], 1'b1};
            end
        end
    end

    // response may come before the instruction fetch finishes
    always_ff @(posedge clk) begin
        if (dmem_resp) begin
            load_q <= dmem_rdata;
        end
    end

    assign dmem_req   = step_start &&
                        (ex_in.kind == rv32i_types::op_lw || ex_in.kind == rv32i_types::op_sw);
    assign dmem_we    = (ex_in.kind == rv32i_types::op_sw);
    assign dmem_addr  = ex_in.result;
    assign dmem_wdata = ex_in.store_data;

    assign writes   = fill[2] && (ex_in.rd != '0) && (ex_in.kind == rv32i_types::op_addi ||
                      ex_in.kind == rv32i_types::op_add || ex_in.kind == rv32i_types::op_lw);
    assign wr_value = (ex_in.kind != rv32i_types::op_lw) ? ex_in.result :
                      dmem_resp ? dmem_rdata : load_q;

    assign wb_valid = writes;
    assign wb_rd    = ex_in.rd;
    assign wb_data  = wr_value;

    assign retire_valid = move && fill[2];
    assign retire_rd    = writes ? ex_in.rd : '0;
    assign retire_data  = writes ? wr_value : '0;

endmodule

// File: logic/rv32i_stall_top.sv
// top level wiring the three stages and the stall FSM to memory and retire ports

module rv32i_stall_top (
    input   logic                   clk,
    input   logic                   rst,

    output  logic                   imem_req,
    output  rv32i_types::word_t     imem_addr,
    input   logic                   imem_resp,
    input   rv32i_types::word_t     imem_rdata,

    output  logic                   dmem_req,
    output  logic                   dmem_we,
    output  rv32i_types::word_t     dmem_addr,
    output  rv32i_types::word_t     dmem_wdata,
    input   logic                   dmem_resp,
    input   rv32i_types::word_t     dmem_rdata,

    output  logic                   retire_valid,
    output  rv32i_types::reg_idx_t  retire_rd,
    output  rv32i_types::word_t     retire_data
);

    logic                   move;
    logic                   dmem_next;
    rv32i_types::word_t     instr;
    logic                   wb_valid;
    rv32i_types::reg_idx_t  wb_rd;
    rv32i_types::word_t     wb_data;

    ex_mem_if ex_mem ();

    stall i_stall (
        .clk        (clk),
        .rst        (rst),
        .imem_next  (1'b1),                 // every step fetches.
        .dmem_next  (dmem_next),
        .imem_resp  (imem_resp),
        .dmem_resp  (dmem_resp),
        .move       (move)
    );

    fetch i_fetch (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .instr      (instr)
    );

    decode_execute i_decode_execute (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .instr      (instr),
        .dmem_next  (dmem_next),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .ex_out     (ex_mem.src)
    );

    mem_writeback i_mem_writeback (
        .clk          (clk),
        .rst          (rst),
        .move         (move),
        .ex_in        (ex_mem.dst),
        .dmem_req     (dmem_req),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// File: tests/clock_gen.sv
// clock generator and active-low reset held for the first cycles

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 10) rst = 1'b1;                      // released just after the edge.
    end

endmodule

// File: tests/rv32i_stall_tb.sv
// testbench with random program, variable latency memories, reference model and watchdog

`include "rv32i_config.svh"

module rv32i_stall_tb;

    localparam int PROG_LEN     = 200;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 64;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG     = PROG_LEN * 2 * 7 * CLK_PERIOD + 100 * CLK_PERIOD;
    localparam rv32i_types::word_t NOP_WORD = {25'b0, `OPC_OP_IMM};

    logic                   clk, rst;
    logic                   imem_req, imem_resp, dmem_req, dmem_we, dmem_resp;
    rv32i_types::word_t     imem_addr, imem_rdata;
    rv32i_types::word_t     dmem_addr, dmem_wdata, dmem_rdata;
    logic                   retire_valid;
    rv32i_types::reg_idx_t  retire_rd;
    rv32i_types::word_t     retire_data;

    integer                 seed = 32'he10e;
    rv32i_types::word_t     prog [IMEM_WORDS];
    rv32i_types::word_t     data_mem [DMEM_WORDS];

    // expected streams from the reference model
    rv32i_types::reg_idx_t  exp_rd [$];
    rv32i_types::word_t     exp_data [$];
    rv32i_types::word_t     exp_st_addr [$];
    rv32i_types::word_t     exp_st_data [$];
    rv32i_types::word_t     exp_ld_addr [$];

    int                     imem_wait = 0;
    int                     dmem_wait = 0;
    rv32i_types::word_t     imem_word, dmem_word;
    int                     imem_pending = 0;
    int                     dmem_pending = 0;
    rv32i_types::word_t     next_fetch = `RESET_PC;
    bit                     reset_done = 1'b0;
    int                     retire_count = 0;
    int                     mixed_steps = 0;
    int                     checks = 0;
    int                     err_reset = 0;
    int                     err_fetch = 0;
    int                     err_retire = 0;
    int                     err_mem = 0;
    int                     err_stall = 0;
    int                     total;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rv32i_stall_top i_rv32i_stall_top (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    //////////////////////////////////////////////////
    // program and reference model
    //////////////////////////////////////////////////

    function automatic rv32i_types::word_t fill_word(input int idx);
        logic [7:0] a;
        a = idx * 4;                                    // byte address.
        return {a, ~a, a ^ 8'h5a, 8'h3c};
    endfunction

    function automatic rv32i_types::op_kind kind_of(input rv32i_types::word_t w);
        if (w[6:0] == `OPC_OP_IMM && w[14:12] == 3'b000) return rv32i_types::op_addi;
        if (w[6:0] == `OPC_OP && w[14:12] == 3'b000 && w[31:25] == 7'b0) return rv32i_types::op_add;
        if (w[6:0] == `OPC_LOAD && w[14:12] == 3'b010) return rv32i_types::op_lw;
        if (w[6:0] == `OPC_STORE && w[14:12] == 3'b010) return rv32i_types::op_sw;
        return rv32i_types::op_nop;
    endfunction

    task automatic build_program();
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, off;
        logic [5:0]  word_idx;
        int          sel;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = NOP_WORD;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rd       = $random(seed) & 7;
            rs1      = $random(seed) & 7;
            rs2      = $random(seed) & 7;
            imm      = $random(seed);
            word_idx = $random(seed);
            sel      = $random(seed) & 3;
            off      = {4'b0000, word_idx, 2'b00};
            if (i % 5 == 4) begin                       // unsupported encodings.
                case (sel)
                    0: prog[i] = {7'b0100000, rs2, rs1, 3'b000, rd, `OPC_OP};
                    1: prog[i] = {imm, 5'd0, 3'b000, rd, `OPC_LOAD};
                    2: prog[i] = {imm, rs1, 3'b001, rd, `OPC_OP_IMM};
                    default: prog[i] = {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};
                endcase
            end else begin
                case (sel)
                    0: prog[i] = {imm, rs1, 3'b000, rd, `OPC_OP_IMM};
                    1: prog[i] = {7'b0, rs2, rs1, 3'b000, rd, `OPC_OP};
                    2: prog[i] = {off, 5'd0, 3'b010, rd, `OPC_LOAD};
                    default: prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], `OPC_STORE};
                endcase
            end
        end
    endtask

    task automatic run_reference();
        rv32i_types::word_t  x [`NUM_REGS];
        rv32i_types::word_t  mem [DMEM_WORDS];
        rv32i_types::word_t  w, val, addr, imm_i, imm_s;
        rv32i_types::op_kind k;
        logic [4:0]          rd;
        for (int r = 0; r < `NUM_REGS; r++) begin
            x[r] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            mem[m] = fill_word(m);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w     = prog[i];
            k     = kind_of(w);
            rd    = w[11:7];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            val   = '0;
            case (k)
                rv32i_types::op_addi: val = x[w[19:15]] + imm_i;
                rv32i_types::op_add:  val = x[w[19:15]] + x[w[24:20]];
                rv32i_types::op_lw: begin
                    addr = x[w[19:15]] + imm_i;
                    exp_ld_addr.push_back(addr);
                    val = mem[addr[7:2]];
                end
                rv32i_types::op_sw: begin
                    addr = x[w[19:15]] + imm_s;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(x[w[24:20]]);
                    mem[addr[7:2]] = x[w[24:20]];
                end
                default: val = '0;
            endcase
            if (rd != 0 && (k == rv32i_types::op_addi || k == rv32i_types::op_add ||
                            k == rv32i_types::op_lw)) begin
                x[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end else begin
                exp_rd.push_back('0);                   // stores, nops and x0.
                exp_data.push_back('0);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst && imem_req) begin
            imem_wait = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            imem_word = (imem_addr[31:2] < IMEM_WORDS) ? prog[imem_addr[31:2]] : NOP_WORD;
        end
        if (rst && dmem_req) begin
            dmem_wait = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            if (dmem_we) begin
                data_mem[dmem_addr[7:2]] = dmem_wdata;
            end
            dmem_word = data_mem[dmem_addr[7:2]];
        end
    end

    always @(posedge clk) begin
        #10;
        imem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        if (imem_wait > 0) begin
            imem_wait--;
            if (imem_wait == 0) begin
                imem_resp  = 1'b1;
                imem_rdata = imem_word;
            end
        end
        if (dmem_wait > 0) begin
            dmem_wait--;
            if (dmem_wait == 0) begin
                dmem_resp  = 1'b1;
                dmem_rdata = dmem_word;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic check_retire();
        rv32i_types::reg_idx_t want_rd;
        rv32i_types::word_t    want_data;
        want_rd   = '0;
        want_data = '0;                                 // trailing nops.
        if (exp_rd.size() > 0) begin
            want_rd   = exp_rd.pop_front();
            want_data = exp_data.pop_front();
        end
        checks++;
        if (imem_pending != 0 || dmem_pending != 0) begin
            $display("FAIL %0t: retire with %0d imem and %0d dmem responses outstanding",
                     $time, imem_pending, dmem_pending);
            err_stall++;
        end
        if (retire_rd !== want_rd || retire_data !== want_data) begin
            $display("FAIL %0t: retire %0d gave x%0d = %h, expected x%0d = %h",
                     $time, retire_count, retire_rd, retire_data, want_rd, want_data);
            err_retire++;
        end
        retire_count++;
    endtask

    task automatic check_fetch();
        checks++;
        if (!reset_done) begin
            reset_done = 1'b1;
            if (imem_addr !== `RESET_PC) begin
                $display("FAIL %0t: first fetch from %h, not the reset PC", $time, imem_addr);
                err_reset++;
            end
            report_test("reset", err_reset);
        end
        if (imem_addr !== next_fetch) begin
            $display("FAIL %0t: fetch from %h, expected %h", $time, imem_addr, next_fetch);
            err_fetch++;
        end
        if (imem_pending != 0) begin
            $display("FAIL %0t: fetch issued before the previous response", $time);
            err_fetch++;
        end
        next_fetch = next_fetch + 32'd4;
        imem_pending++;
    endtask

    task automatic check_data_req();
        rv32i_types::word_t want_addr, want_data;
        checks++;
        if (dmem_we && exp_st_addr.size() == 0) begin
            $display("FAIL %0t: store to %h not in the program", $time, dmem_addr);
            err_mem++;
        end else if (dmem_we) begin
            want_addr = exp_st_addr.pop_front();
            want_data = exp_st_data.pop_front();
            if (dmem_addr !== want_addr || dmem_wdata !== want_data) begin
                $display("FAIL %0t: store %h to %h, expected %h to %h",
                         $time, dmem_wdata, dmem_addr, want_data, want_addr);
                err_mem++;
            end
        end else if (exp_ld_addr.size() == 0) begin
            $display("FAIL %0t: load from %h not in the program", $time, dmem_addr);
            err_mem++;
        end else begin
            want_addr = exp_ld_addr.pop_front();
            if (dmem_addr !== want_addr) begin
                $display("FAIL %0t: load from %h, expected %h", $time, dmem_addr, want_addr);
                err_mem++;
            end
        end
        if (dmem_pending != 0) begin
            $display("FAIL %0t: data request before the previous response", $time);
            err_stall++;
        end
        dmem_pending++;
    endtask

    // sampled mid-cycle with responses counted before requests
    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            if (imem_req || dmem_req || retire_valid) begin
                $display("FAIL %0t: request or retire active during reset", $time);
                err_reset++;
            end
            if (i_rv32i_stall_top.i_stall.curr_state != rv32i_types::idle) begin
                $display("FAIL %0t: stall FSM not idle during reset", $time);
                err_reset++;
            end
        end else begin
            if (imem_resp) imem_pending--;
            if (dmem_resp) dmem_pending--;
            if (retire_valid) check_retire();
            if (imem_req) check_fetch();
            if (dmem_req) check_data_req();
            if (imem_req && dmem_req) mixed_steps++;
        end
    end

    //////////////////////////////////////////////////
    // sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        imem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        for (int m = 0; m < DMEM_WORDS; m++) begin
            data_mem[m] = fill_word(m);
        end
        build_program();
        run_reference();
        wait (retire_count == PROG_LEN);
        @(posedge clk);
        if (exp_st_addr.size() != 0 || exp_ld_addr.size() != 0) begin
            $display("FAIL %0t: %0d stores and %0d loads never requested",
                     $time, exp_st_addr.size(), exp_ld_addr.size());
            err_mem++;
        end
        if (mixed_steps == 0) begin
            $display("no step had both memory requests outstanding");
            err_stall++;
        end
        report_test("fetch order", err_fetch);
        report_test("retire stream", err_retire);
        report_test("stores and loads", err_mem);
        report_test("mixed latency stall", err_stall);
        total = err_reset + err_fetch + err_retire + err_mem + err_stall;
        $display("%0d checks, %0d errors, %0d retired, %0d steps with both requests",
                 checks, total, retire_count, mixed_steps);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog: the run hung with %0d of %0d instructions retired",
                 retire_count, PROG_LEN);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: rv32i_stall.f
+incdir+include
logic/rv32i_types.sv
logic/ex_mem_if.sv
logic/stall.sv
logic/fetch.sv
logic/decode_execute.sv
logic/mem_writeback.sv
logic/rv32i_stall_top.sv
tests/clock_gen.sv
tests/rv32i_stall_tb.sv
